//--- backend_pkg.sv
/* Shared widths, sizes and types of the backend. Sizes are fixed: the free list
   depth must stay a power of two for its wrapping pointers. */
package backend_pkg;

    localparam int xlen       = 32;
    localparam int num_lregs  = 32;
    localparam int num_pregs  = 64;
    localparam int lreg_w     = 5;
    localparam int preg_w     = 6;
    localparam int rob_depth  = 16;
    localparam int robid_w    = 4;
    localparam int free_depth = num_pregs - num_lregs;   // pregs not mapped at reset
    localparam int fl_ptr_w   = $clog2(free_depth);

    typedef logic [preg_w-1:0]  preg_t;
    typedef logic [robid_w-1:0] robid_t;

    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_other = 7'b0000000
    } opcode_e;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt} alu_op_e;

    typedef struct packed {
        logic [xlen-1:0]   pc;
        logic [lreg_w-1:0] lrd;
        logic [lreg_w-1:0] lrs1;
        logic [lreg_w-1:0] lrs2;
        logic [xlen-1:0]   imm;          // sign-extended I-type
        alu_op_e           alu_op;
        logic              src2_is_imm;
        logic              need_to_wb;
        preg_t             prd;
        preg_t             prs1;
        preg_t             prs2;
        preg_t             old_prd;
    } uop_t;

    typedef struct packed {
        logic            valid;
        robid_t          robid;
        preg_t           prd;
        logic            need_to_wb;
        logic [xlen-1:0] result;
    } wb_t;

    typedef struct packed {
        robid_t          robid;
        preg_t           prd;
        logic            need_to_wb;
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
        alu_op_e         alu_op;
        logic [xlen-1:0] pc;
    } issue_t;

endpackage

//--- uop_if.sv
/* Valid/ready link for one uop. The source holds valid and uop stable until
   the transfer. */
interface uop_if;
    import backend_pkg::*;

    logic valid;
    logic ready;
    uop_t uop;

    modport src (
        output valid,
        output uop,
        input  ready
    );

    modport dst (
        input  valid,
        input  uop,
        output ready
    );

endinterface

//--- decode_unit.sv
/* Decodes the RV32I ALU subset only. Any other word, including shifts, SLTU and
   M-extension ops, becomes a non-writing NOP that still commits. */
module decode_unit (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        ibuffer_instr_valid,
    input  logic [31:0] ibuffer_inst_out,
    input  logic [31:0] ibuffer_pc_out,
    output logic        ibuffer_instr_ready,
    uop_if.src          out
);
    import backend_pkg::*;

    opcode_e    opc;
    uop_t       dec;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = ibuffer_inst_out[14:12];
    assign funct7 = ibuffer_inst_out[31:25];
    assign ibuffer_instr_ready = !out.valid || out.ready;   // empty or draining

    always_comb begin
        logic supported;
        case (ibuffer_inst_out[6:0])
            op_reg:  opc = op_reg;
            op_imm:  opc = op_imm;
            default: opc = op_other;
        endcase
        dec = '0;
        dec.pc = ibuffer_pc_out;
        dec.lrd = ibuffer_inst_out[11:7];
        dec.lrs1 = ibuffer_inst_out[19:15];
        dec.lrs2 = ibuffer_inst_out[24:20];
        dec.imm = {{(xlen-12){ibuffer_inst_out[31]}}, ibuffer_inst_out[31:20]};
        dec.src2_is_imm = (opc == op_imm);
        supported = 1'b1;
        case (funct3)
            3'b000:  dec.alu_op = (opc == op_reg && funct7[5]) ? alu_sub : alu_add;
            3'b111:  dec.alu_op = alu_and;
            3'b110:  dec.alu_op = alu_or;
            3'b100:  dec.alu_op = alu_xor;
            3'b010:  dec.alu_op = alu_slt;
            default: supported = 1'b0;
        endcase
        // R-type allows funct7 of zero, or 0100000 only for SUB
        if (opc == op_reg && funct7 != 7'b0 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
            supported = 1'b0;
        end
        dec.need_to_wb = supported && opc != op_other && dec.lrd != '0;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else if (ibuffer_instr_ready) begin
            out.valid <= ibuffer_instr_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (ibuffer_instr_valid && ibuffer_instr_ready) begin
            out.uop <= dec;
        end
    end

endmodule

//--- rename_unit.sv
/* Rename with no recovery: table and free list are only rolled forward.
   Stalls while the free list is empty and the uop needs a destination. */
module rename_unit (
    input  logic               clock,
    input  logic               rst_n,
    uop_if.dst                 in,
    uop_if.src                 out,
    input  logic               release_valid,
    input  backend_pkg::preg_t release_preg
);
    import backend_pkg::*;

    preg_t               rat [num_lregs];
    preg_t               fl  [free_depth];
    logic [fl_ptr_w-1:0] fl_head;
    logic [fl_ptr_w-1:0] fl_tail;
    logic [fl_ptr_w:0]   fl_count;
    logic                out_free;
    logic                accept;
    logic                pop;
    uop_t                ren;

    assign out_free = !out.valid || out.ready;
    assign in.ready = out_free && !(in.uop.need_to_wb && fl_count == '0);
    assign accept = in.valid && in.ready;
    assign pop = accept && in.uop.need_to_wb;

    always_comb begin
        ren = in.uop;
        ren.prs1 = rat[in.uop.lrs1];
        ren.prs2 = rat[in.uop.lrs2];
        ren.old_prd = rat[in.uop.lrd];                        // freed at commit
        ren.prd = in.uop.need_to_wb ? fl[fl_head] : '0;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_lregs; i++) begin
                rat[i] <= preg_t'(i);                         // identity map
            end
            for (int i = 0; i < free_depth; i++) begin
                fl[i] <= preg_t'(num_lregs + i);
            end
            fl_head <= '0;
            fl_tail <= '0;
            fl_count <= (fl_ptr_w+1)'(free_depth);
        end else begin
            if (pop) begin
                rat[in.uop.lrd] <= fl[fl_head];
                fl_head <= fl_head + 1'b1;
            end
            if (release_valid) begin
                fl[fl_tail] <= release_preg;
                fl_tail <= fl_tail + 1'b1;
            end
            fl_count <= fl_count + (fl_ptr_w+1)'(release_valid) - (fl_ptr_w+1)'(pop);
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else if (out_free) begin
            out.valid <= accept;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            out.uop <= ren;
        end
    end

    a_fl_no_overflow: assert property (@(posedge clock) disable iff (!rst_n)
        release_valid && !pop |-> fl_count != (fl_ptr_w+1)'(free_depth));

endmodule

//--- issue_rob.sv
/* One ALU port, no operand bypass: a dependent issues the cycle after writeback.
   Entries without a destination are done at allocation and never issue. */
module issue_rob (
    input  logic                clock,
    input  logic                rst_n,
    uop_if.dst                  in,
    output logic                issue_valid,
    output backend_pkg::issue_t issue_data,
    input  backend_pkg::wb_t    wb,
    output logic                release_valid,
    output backend_pkg::preg_t  release_preg,
    output logic                commit_valid,
    output logic [31:0]         commit_pc,
    output logic [4:0]          commit_lrd,
    output logic [31:0]         commit_data
);
    import backend_pkg::*;

    uop_t                 rob_uop    [rob_depth];
    logic [xlen-1:0]      rob_result [rob_depth];
    logic [rob_depth-1:0] rob_issued;
    logic [rob_depth-1:0] rob_done;
    robid_t               head;
    robid_t               tail;
    robid_t               sel;
    logic [robid_w:0]     count;
    logic [num_pregs-1:0] preg_rdy;
    logic [xlen-1:0]      prf [num_pregs];
    logic                 alloc;
    uop_t                 sel_uop;
    uop_t                 head_uop;

    assign in.ready = count != (robid_w+1)'(rob_depth);
    assign alloc = in.valid && in.ready;

    // oldest unissued entry with both sources ready
    always_comb begin
        robid_t idx;
        issue_valid = 1'b0;
        sel = head;
        for (int i = 0; i < rob_depth; i++) begin
            idx = head + robid_t'(i);
            if (!issue_valid && i < int'(count) && !rob_issued[idx] &&
                preg_rdy[rob_uop[idx].prs1] &&
                (rob_uop[idx].src2_is_imm || preg_rdy[rob_uop[idx].prs2])) begin
                issue_valid = 1'b1;
                sel = idx;
            end
        end
    end

    assign sel_uop = rob_uop[sel];
    assign issue_data = '{robid: sel, prd: sel_uop.prd, need_to_wb: sel_uop.need_to_wb,
                          src1: prf[sel_uop.prs1],
                          src2: sel_uop.src2_is_imm ? sel_uop.imm : prf[sel_uop.prs2],
                          alu_op: sel_uop.alu_op, pc: sel_uop.pc};

    assign head_uop = rob_uop[head];
    assign commit_valid = count != '0 && rob_done[head];
    assign commit_pc = head_uop.pc;
    assign commit_lrd = head_uop.lrd;
    assign commit_data = head_uop.need_to_wb ? rob_result[head] : '0;
    assign release_valid = commit_valid && head_uop.need_to_wb;
    assign release_preg = head_uop.old_prd;               // previous mapping is dead now

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            rob_issued <= '0;
            rob_done <= '0;
        end else begin
            if (alloc) begin
                rob_issued[tail] <= !in.uop.need_to_wb;
                rob_done[tail] <= !in.uop.need_to_wb;
                tail <= tail + robid_t'(1);
            end
            if (issue_valid) begin
                rob_issued[sel] <= 1'b1;
            end
            if (wb.valid) begin
                rob_done[wb.robid] <= 1'b1;
            end
            if (commit_valid) begin
                head <= head + robid_t'(1);
            end
            count <= count + (robid_w+1)'(alloc) - (robid_w+1)'(commit_valid);
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            rob_uop[tail] <= in.uop;
        end
        if (wb.valid) begin
            rob_result[wb.robid] <= wb.result;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            preg_rdy <= '1;
            for (int i = 0; i < num_pregs; i++) begin
                prf[i] <= '0;
            end
        end else begin
            if (wb.valid && wb.need_to_wb) begin
                preg_rdy[wb.prd] <= 1'b1;
                prf[wb.prd] <= wb.result;
            end
            if (alloc && in.uop.need_to_wb) begin
                preg_rdy[in.uop.prd] <= 1'b0;             // pending until writeback
            end
        end
    end

    a_in_held_when_full: assert property (@(posedge clock) disable iff (!rst_n)
        in.valid && !in.ready |=> in.valid && $stable(in.uop));
    a_wb_to_issued: assert property (@(posedge clock) disable iff (!rst_n)
        wb.valid |-> rob_issued[wb.robid] && !rob_done[wb.robid]);

endmodule

//--- int_alu.sv
/* Single-cycle ALU that accepts every cycle, so there is no ready.
   SLT compares signed. */
module int_alu (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                issue_valid,
    input  backend_pkg::issue_t issue_data,
    output backend_pkg::wb_t    wb
);
    import backend_pkg::*;

    logic [xlen-1:0] result;
    logic [xlen-1:0] result_q;
    logic            valid_q;
    logic            need_to_wb_q;
    robid_t          robid_q;
    preg_t           prd_q;

    always_comb begin
        case (issue_data.alu_op)
            alu_add: result = issue_data.src1 + issue_data.src2;
            alu_sub: result = issue_data.src1 - issue_data.src2;
            alu_and: result = issue_data.src1 & issue_data.src2;
            alu_or:  result = issue_data.src1 | issue_data.src2;
            alu_xor: result = issue_data.src1 ^ issue_data.src2;
            alu_slt: result = {{(xlen-1){1'b0}}, $signed(issue_data.src1) < $signed(issue_data.src2)};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            result_q <= result;
            robid_q <= issue_data.robid;
            prd_q <= issue_data.prd;
            need_to_wb_q <= issue_data.need_to_wb;
        end
    end

    assign wb = '{valid: valid_q, robid: robid_q, prd: prd_q,
                  need_to_wb: need_to_wb_q, result: result_q};

endmodule

//--- backend.sv
/* Single-issue backend for the RV32I ALU subset. No branches, memory ops or
   flush; the commit port has no back-pressure. */
module backend (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        ibuffer_instr_valid,
    output logic        ibuffer_instr_ready,
    input  logic [31:0] ibuffer_inst_out,
    input  logic [31:0] ibuffer_pc_out,
    output logic        commit_valid,
    output logic [31:0] commit_pc,
    output logic [4:0]  commit_lrd,
    output logic [31:0] commit_data
);
    import backend_pkg::*;

    logic   issue_valid;
    issue_t issue_data;
    wb_t    wb;
    logic   release_valid;
    preg_t  release_preg;

    uop_if dec2ren ();
    uop_if ren2rob ();

    decode_unit u_decode_unit (
        .clock              (clock),
        .rst_n              (rst_n),
        .ibuffer_instr_valid(ibuffer_instr_valid),
        .ibuffer_inst_out   (ibuffer_inst_out),
        .ibuffer_pc_out     (ibuffer_pc_out),
        .ibuffer_instr_ready(ibuffer_instr_ready),
        .out                (dec2ren.src)
    );

    rename_unit u_rename_unit (
        .clock        (clock),
        .rst_n        (rst_n),
        .in           (dec2ren.dst),
        .out          (ren2rob.src),
        .release_valid(release_valid),
        .release_preg (release_preg)
    );

    issue_rob u_issue_rob (
        .clock        (clock),
        .rst_n        (rst_n),
        .in           (ren2rob.dst),
        .issue_valid  (issue_valid),
        .issue_data   (issue_data),
        .wb           (wb),
        .release_valid(release_valid),
        .release_preg (release_preg),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_lrd   (commit_lrd),
        .commit_data  (commit_data)
    );

    int_alu u_int_alu (
        .clock      (clock),
        .rst_n      (rst_n),
        .issue_valid(issue_valid),
        .issue_data (issue_data),
        .wb         (wb)
    );

endmodule

//--- tb_backend.sv
/* Runs the program from backend_tests.txt three times in a row against a register model.
   Commits must arrive in program order, and pc runs on from 0x1000 across the passes. */
module tb_backend;

    localparam int          passes    = 3;
    localparam int          max_words = 64;
    localparam logic [31:0] base_pc   = 32'h0000_1000;

    logic        clock;
    logic        rst_n;
    logic        ibuffer_instr_valid;
    logic        ibuffer_instr_ready;
    logic [31:0] ibuffer_inst_out;
    logic [31:0] ibuffer_pc_out;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic [4:0]  commit_lrd;
    logic [31:0] commit_data;

    logic [31:0] prog [0:max_words-1];
    logic [31:0] regs [0:31];           // reference architectural state
    int          num_words;
    int          total;
    integer      seed;

    backend u_dut (
        .clock              (clock),
        .rst_n              (rst_n),
        .ibuffer_instr_valid(ibuffer_instr_valid),
        .ibuffer_instr_ready(ibuffer_instr_ready),
        .ibuffer_inst_out   (ibuffer_inst_out),
        .ibuffer_pc_out     (ibuffer_pc_out),
        .commit_valid       (commit_valid),
        .commit_pc          (commit_pc),
        .commit_lrd         (commit_lrd),
        .commit_data        (commit_data)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    // executes one instruction on the register model, returns the commit data
    task automatic ref_step(input logic [31:0] inst, output logic [31:0] data);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic        ok;
        opc = inst[6:0];
        f3 = inst[14:12];
        f7 = inst[31:25];
        a = regs[inst[19:15]];
        b = (opc == 7'h13) ? {{20{inst[31]}}, inst[31:20]} : regs[inst[24:20]];
        ok = (opc == 7'h13) || (opc == 7'h33 && (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'd0)));
        case (f3)
            3'd0:    r = (opc == 7'h33 && f7 == 7'h20) ? a - b : a + b;
            3'd7:    r = a & b;
            3'd6:    r = a | b;
            3'd4:    r = a ^ b;
            3'd2:    r = {31'b0, $signed(a) < $signed(b)};
            default: begin
                r = '0;
                ok = 1'b0;
            end
        endcase
        if (!ok || inst[11:7] == 5'd0) begin
            r = '0;                       // nop or x0 write
        end else begin
            regs[inst[11:7]] = r;
        end
        data = r;
    endtask

    task automatic drive_stimulus();
        int   sent;
        logic xfer;
        sent = 0;
        while (sent < total) begin
            @(posedge clock);
            xfer = ibuffer_instr_valid && ibuffer_instr_ready;
            if (xfer) begin
                sent++;
            end
            if (xfer || !ibuffer_instr_valid) begin
                if (sent < total && ($random(seed) & 3) != 0) begin
                    ibuffer_instr_valid <= 1'b1;
                    ibuffer_inst_out <= prog[sent % num_words];
                    ibuffer_pc_out <= base_pc + 32'(4 * sent);
                end else begin
                    ibuffer_instr_valid <= 1'b0;   // gap, or all words sent
                end
            end
        end
    endtask

    task automatic watch_commits();
        int          committed;
        int          cycles;
        logic [31:0] inst;
        logic [31:0] exp_data;
        committed = 0;
        cycles = 0;
        while (committed < total) begin
            @(posedge clock);
            cycles++;
            if (cycles > 20 * total + 100) begin
                $display("timeout: commits stalled after %0d of %0d instructions",
                         committed, total);
                $display("*** TEST FAILED ***");
                $fatal(1);
            end else if (commit_valid) begin
                inst = prog[committed % num_words];
                ref_step(inst, exp_data);
                check_value("commit_pc", commit_pc, base_pc + 32'(4 * committed));
                check_value("commit_lrd", 32'(commit_lrd), 32'(inst[11:7]));
                check_value("commit_data", commit_data, exp_data);
                committed++;
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        ibuffer_instr_valid = 1'b0;
        ibuffer_inst_out = '0;
        ibuffer_pc_out = '0;
        seed = 32'h7d0c;
        for (int i = 0; i < max_words; i++) begin
            prog[i] = '1;                 // end marker, never a program word
        end
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        $readmemh("backend_tests.txt", prog);
        num_words = 0;
        while (num_words < max_words && prog[num_words] != '1) begin
            num_words++;
        end
        total = passes * num_words;
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
        check_value("ibuffer_instr_ready", 32'(ibuffer_instr_ready), 32'd1);
        fork
            drive_stimulus();
            watch_commits();
        join
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- backend_tests.txt
// one 32-bit RV32I instruction word per line, in hex, in program order
// expected commit values come from the register model in the testbench
00500093 // addi x1, x0, 5
FFD00113 // addi x2, x0, -3
002081B3 // add  x3, x1, x2
40208233 // sub  x4, x1, x2
003272B3 // and  x5, x4, x3
0022E333 // or   x6, x5, x2
001343B3 // xor  x7, x6, x1
00112433 // slt  x8, x2, x1
00112493 // slti x9, x2, 1
FFF0A513 // slti x10, x1, -1
00108033 // add  x0, x1, x1
0000A103 // lw   x2, 0(x1) is not supported
003065B3 // or   x11, x0, x3
00708093 // addi x1, x1, 7
001080B3 // add  x1, x1, x1
40208133 // sub  x2, x1, x2
FFF14193 // xori x3, x2, -1
0F01F613 // andi x12, x3, 0xf0
7FF66693 // ori  x13, x12, 0x7ff
0036A733 // slt  x14, x13, x3
001097B3 // sll  x15, x1, x1 is not supported

//--- compile.f
backend_pkg.sv
uop_if.sv
decode_unit.sv
rename_unit.sv
issue_rob.sv
int_alu.sv
backend.sv
tb_backend.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_backend
FILELIST  = compile.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
